//--- Bender.yml
package:
  name: mips_core

sources:
  - verilog/mipsIsaPkg.sv
  - verilog/mipsCorePkg.sv
  - verilog/ctrlIf.sv
  - verilog/mipsDecoder.sv
  - verilog/regFile.sv
  - verilog/mipsAlu.sv
  - verilog/pcUnit.sv
  - verilog/mipsCore.sv
  - target: test
    files:
      - test/mipsCore_chk.sv
      - test/mipsCoreTb.sv

//--- build.f
verilog/mipsIsaPkg.sv
verilog/mipsCorePkg.sv
verilog/ctrlIf.sv
verilog/mipsDecoder.sv
verilog/regFile.sv
verilog/mipsAlu.sv
verilog/pcUnit.sv
verilog/mipsCore.sv
test/mipsCore_chk.sv
test/mipsCoreTb.sv

//--- test/mipsCoreTb.sv
// testbench for the single-cycle MIPS core: clock, reset, ROM and RAM models, data-file checks
`timescale 1ns/10ps

module mipsCoreTb;

  // ==================================================
  // data file layout, word offsets
  // ==================================================
  localparam int RomWords  = 64;
  localparam int CountBase = 'h40;
  localparam int CycleBase = 'h80;
  localparam int PairBase  = 'h100;
  localparam int DataWords = 512;
  localparam int MaxCycles = 200;

  logic                   clk;
  logic                   rst;
  mipsIsaPkg::word_t      irAddr;
  mipsIsaPkg::word_t      ir;
  mipsIsaPkg::word_t      memReadData;
  logic                   cen;
  logic                   wen;
  mipsCorePkg::dmemAddr_t memAddr;
  mipsIsaPkg::word_t      memWriteData;
  mipsIsaPkg::word_t      rfWriteData;

  mipsIsaPkg::word_t      testData [0:DataWords-1];
  mipsIsaPkg::word_t      rom [0:RomWords-1];
  mipsIsaPkg::word_t      ram [0:mipsCorePkg::DmemWords-1];
  mipsCorePkg::dmemAddr_t fillAddr;
  mipsIsaPkg::opcode_t    expOpcode;
  logic                   expCen;
  logic                   expWen;
  int                     errors;
  int                     cycleCount;
  int                     pairCount;
  int                     cycle;

  mipsCore u_mipsCore (
    .clk(clk), .rst(rst), .irAddr(irAddr), .ir(ir), .memReadData(memReadData),
    .cen(cen), .wen(wen), .memAddr(memAddr), .memWriteData(memWriteData),
    .rfWriteData(rfWriteData)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // ==================================================
  // memory models
  // ==================================================
  // word-indexed ROM
  assign ir = rom[irAddr[7:2]];
  // read data only while enabled for a read
  assign memReadData = (!cen && wen) ? ram[memAddr] : '0;

  always @(posedge clk) begin
    if (!cen && !wen) begin
      ram[memAddr] <= memWriteData;
    end
  end

  task automatic checkValue(input string name, input mipsIsaPkg::word_t expected,
                            input mipsIsaPkg::word_t actual);
    if (actual !== expected) begin
      errors++;
      $display("Fail %s: expected %08h, actual %08h", name, expected, actual);
    end
  endtask

  initial begin
    int base;
    errors = 0;
    rst = 1'b0;
    for (int i = 0; i < DataWords; i++) begin
      testData[i] = '0;
    end
    $readmemh("test/mipsTestdata.txt", testData);
    for (int i = 0; i < RomWords; i++) begin
      rom[i] = testData[i];
    end
    // odd words negative, low bits carry the address
    for (int i = 0; i < mipsCorePkg::DmemWords; i++) begin
      fillAddr = i;
      ram[i] <= {{16{fillAddr[0]}}, 9'd0, fillAddr};
    end
    cycleCount = testData[CountBase];
    pairCount  = testData[CountBase + 1];
    if (cycleCount == 0) begin
      errors++;
      $display("test data file holds no cycle records");
    end

    // reset for 5 cycles, released on a falling edge
    repeat (5) @(negedge clk);
    rst = 1'b1;

    // one record per instruction, sampled mid-cycle
    cycle = 0;
    while (cycle < cycleCount && cycle < MaxCycles) begin
      base = CycleBase + 3 * cycle;
      checkValue($sformatf("cycle %0d irAddr", cycle), testData[base], irAddr);
      // flag clear for instructions that write no register
      if (testData[base + 2][0]) begin
        checkValue($sformatf("cycle %0d rfWriteData", cycle), testData[base + 1], rfWriteData);
      end
      // chip enable for lw and sw, write enable for sw only
      expOpcode = rom[testData[base][7:2]][31:26];
      expWen = (expOpcode != mipsIsaPkg::OpSw);
      expCen = expWen && (expOpcode != mipsIsaPkg::OpLw);
      checkValue($sformatf("cycle %0d cen", cycle), {31'd0, expCen}, {31'd0, cen});
      checkValue($sformatf("cycle %0d wen", cycle), {31'd0, expWen}, {31'd0, wen});
      cycle++;
      @(negedge clk);
    end

    if (cycle < cycleCount) begin
      errors++;
      $display("simulation did not reach the end of the program");
    end else begin
      // final data memory image
      for (int p = 0; p < pairCount; p++) begin
        base = PairBase + 2 * p;
        checkValue($sformatf("ram[%0d]", testData[base]), testData[base + 1],
                   ram[testData[base][6:0]]);
      end
    end

    $display("cycles checked %0d, errors %0d", cycle, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

//--- test/mipsCore_chk.sv
// bound assertions on the core's instruction fetch and data memory strobes
`timescale 1ns/10ps

module mipsCore_chk (
  input logic              clk,
  input logic              rst,
  input mipsIsaPkg::word_t irAddr,
  input logic              cen,
  input logic              wen
);

  // ==================================================
  // data memory strobes
  // ==================================================
  // write strobe only inside an enabled access
  writeNeedsEnable: assert property (@(posedge clk) disable iff (!rst) !wen |-> !cen)
    else $error("wen low while cen is high");

  // ==================================================
  // instruction port
  // ==================================================
  fetchAligned: assert property (@(posedge clk) disable iff (!rst) irAddr[1:0] == 2'b00)
    else $error("irAddr not word aligned");

  // first fetch after reset from address 0
  fetchFromZero: assert property (@(posedge clk) $rose(rst) |-> irAddr == '0)
    else $error("irAddr not zero after reset");

endmodule

bind mipsCore mipsCore_chk u_mipsCoreChk (
  .clk(clk), .rst(rst), .irAddr(irAddr), .cen(cen), .wen(wen)
);

//--- test/mipsTestdata.txt
// @000 program words, @040 record count and RAM pair count
// @080 cycle records (irAddr, rfWriteData, check flag), @100 final RAM (word address, value)
@000
8C010008 8C02000C 8C030018 00232020 00232822 00433024 00433825 0041402A
0022482A 00035100 00025A02 00630020 00016020 AC240010 8C2D0010 108D0001
00217020 10230005 08000015 00217020 00217020 0C000019 00217020 AC6A0000
08000018 00A77820 AC0F0028 03E00008
@040
00000018 00000004
@080
00000000 00000002 00000001
00000004 FFFF0003 00000001
00000008 00000006 00000001
0000000C 00000008 00000001
00000010 FFFFFFFC 00000001
00000014 00000002 00000001
00000018 FFFF0007 00000001
0000001C 00000001 00000001
00000020 00000000 00000001
00000024 00000060 00000001
00000028 00FFFF00 00000001
0000002C 0000000C 00000001
00000030 00000002 00000001
00000034 00000000 00000000
00000038 00000008 00000001
0000003C 00000000 00000000
00000044 00000000 00000000
00000048 00000000 00000000
00000054 0000005C 00000001
00000064 FFFF0003 00000001
00000068 00000000 00000000
0000006C 00000000 00000000
0000005C 00000000 00000000
00000060 00000000 00000000
@100
00000004 00000008
00000001 00000060
0000000A FFFF0003
00000002 00000002

//--- verilog/ctrlIf.sv
// decoded control bundle interface with decoder and consumer modports
`timescale 1ns/10ps

interface ctrlIf;
  // destination is rd when set, else rt
  logic regDst;
  // operand two from the sign-extended immediate
  logic aluSrcImm;
  logic regWrite;
  logic memRead;
  logic memWrite;
  // beq
  logic branch;
  // j and jal
  logic jump;
  // jr, target from rs
  logic jumpReg;
  // shamt replaces operand one
  logic shiftOp;
  mipsCorePkg::wbSel_t wbSel;
  mipsCorePkg::aluOp_t aluOp;

  modport dec (output regDst, aluSrcImm, regWrite, memRead, memWrite,
               branch, jump, jumpReg, shiftOp, wbSel, aluOp);
  modport user (input regDst, aluSrcImm, regWrite, memRead, memWrite,
                branch, jump, jumpReg, shiftOp, wbSel, aluOp);
endinterface

//--- verilog/mipsAlu.sv
// integer ALU with add, sub, and, or, signed slt, sll, srl and zero flag
`timescale 1ns/10ps

module mipsAlu (
  input  mipsIsaPkg::word_t   opA,
  input  mipsIsaPkg::word_t   opB,
  input  mipsCorePkg::aluOp_t aluOp,
  output mipsIsaPkg::word_t   result,
  output logic                zero
);

  // shift distance from the low bits of operand one
  logic [4:0] shAmt;

  assign shAmt = opA[4:0];

  always_comb begin
    case (aluOp)
      mipsCorePkg::AluAdd: result = opA + opB;
      mipsCorePkg::AluSub: result = opA - opB;
      mipsCorePkg::AluAnd: result = opA & opB;
      mipsCorePkg::AluOr:  result = opA | opB;
      // two's complement compare
      mipsCorePkg::AluSlt: result = {31'd0, $signed(opA) < $signed(opB)};
      // operand two is the value being shifted
      mipsCorePkg::AluSll: result = opB << shAmt;
      mipsCorePkg::AluSrl: result = opB >> shAmt;
      default:             result = '0;
    endcase
  end

  // flag for every op, beq reads it after sub
  assign zero = (result == '0);

endmodule

//--- verilog/mipsCore.sv
// single-cycle MIPS core top: decoder, register file, ALU, pc unit and memory strobes
`timescale 1ns/10ps

module mipsCore (
  input  logic                   clk,
  input  logic                   rst,
  output mipsIsaPkg::word_t      irAddr,
  input  mipsIsaPkg::word_t      ir,
  input  mipsIsaPkg::word_t      memReadData,
  output logic                   cen,
  output logic                   wen,
  output mipsCorePkg::dmemAddr_t memAddr,
  output mipsIsaPkg::word_t      memWriteData,
  output mipsIsaPkg::word_t      rfWriteData
);

  ctrlIf ctrl ();

  mipsIsaPkg::regAddr_t rs;
  mipsIsaPkg::regAddr_t rt;
  mipsIsaPkg::regAddr_t rd;
  mipsIsaPkg::regAddr_t writeAddr;
  mipsIsaPkg::word_t    immExt;
  mipsIsaPkg::word_t    shamtExt;
  mipsIsaPkg::word_t    rsData;
  mipsIsaPkg::word_t    rtData;
  mipsIsaPkg::word_t    opA;
  mipsIsaPkg::word_t    opB;
  mipsIsaPkg::word_t    aluResult;
  mipsIsaPkg::word_t    pcPlus8;
  logic                 aluZero;

  // ==================================================
  // instruction fields
  // ==================================================
  assign rs = ir[25:21];
  assign rt = ir[20:16];
  assign rd = ir[15:11];
  // sign-extended 16-bit immediate
  assign immExt = {{(32 - mipsIsaPkg::ImmWidth){ir[15]}}, ir[mipsIsaPkg::ImmWidth-1:0]};
  assign shamtExt = {{(32 - mipsIsaPkg::ShamtWidth){1'b0}}, ir[10:6]};

  mipsDecoder u_mipsDecoder (.ir(ir), .ctrl(ctrl));

  // jal targets r31, R-type rd, loads rt
  assign writeAddr = (ctrl.wbSel == mipsCorePkg::WbLink) ? mipsIsaPkg::LinkReg :
                     (ctrl.regDst ? rd : rt);

  regFile u_regFile (
    .clk(clk), .rst(rst), .writeEn(ctrl.regWrite),
    .readAddrA(rs), .readAddrB(rt), .writeAddr(writeAddr),
    .writeData(rfWriteData), .readDataA(rsData), .readDataB(rtData)
  );

  // operand muxes
  assign opA = ctrl.shiftOp ? shamtExt : rsData;
  assign opB = ctrl.aluSrcImm ? immExt : rtData;

  mipsAlu u_mipsAlu (
    .opA(opA), .opB(opB), .aluOp(ctrl.aluOp), .result(aluResult), .zero(aluZero)
  );

  pcUnit u_pcUnit (
    .clk(clk), .rst(rst), .ctrl(ctrl),
    .jumpTarget(ir[mipsIsaPkg::TargetWidth-1:0]), .branchOffset(immExt),
    .regTarget(rsData), .aluZero(aluZero), .pc(irAddr), .pcPlus8(pcPlus8)
  );

  // ==================================================
  // writeback and data memory
  // ==================================================
  always_comb begin
    case (ctrl.wbSel)
      mipsCorePkg::WbMem:  rfWriteData = memReadData;
      mipsCorePkg::WbLink: rfWriteData = pcPlus8;
      default:             rfWriteData = aluResult;
    endcase
  end

  // strobes active low
  assign cen = ~(ctrl.memRead | ctrl.memWrite);
  assign wen = ~ctrl.memWrite;
  // byte address to word address
  assign memAddr = aluResult[$bits(mipsCorePkg::dmemAddr_t)+1:2];
  assign memWriteData = rtData;

endmodule

//--- verilog/mipsCorePkg.sv
// core-internal definitions: ALU operation codes, writeback selectors, data memory address type
package mipsCorePkg;

  // ==================================================
  // ALU operations
  // ==================================================
  typedef logic [2:0] aluOp_t;

  localparam aluOp_t AluAdd = 3'd0;
  localparam aluOp_t AluSub = 3'd1;
  localparam aluOp_t AluAnd = 3'd2;
  localparam aluOp_t AluOr  = 3'd3;
  // signed compare
  localparam aluOp_t AluSlt = 3'd4;
  localparam aluOp_t AluSll = 3'd5;
  localparam aluOp_t AluSrl = 3'd6;

  // ==================================================
  // writeback source
  // ==================================================
  typedef logic [1:0] wbSel_t;

  localparam wbSel_t WbAlu  = 2'd0;
  localparam wbSel_t WbMem  = 2'd1;
  // pc + 8, jal only
  localparam wbSel_t WbLink = 2'd2;

  // ==================================================
  // data memory
  // ==================================================
  localparam int DmemWords = 128;

  // word address into the data memory
  typedef logic [$clog2(DmemWords)-1:0] dmemAddr_t;

endpackage

//--- verilog/mipsDecoder.sv
// main control and ALU control decoder, instruction word to control bundle
`timescale 1ns/10ps

module mipsDecoder (
  input  mipsIsaPkg::word_t ir,
  ctrlIf.dec                ctrl
);

  mipsIsaPkg::opcode_t opcode;
  mipsIsaPkg::funct_t  funct;

  assign opcode = ir[31:26];
  assign funct  = ir[5:0];

  always_comb begin
    // defaults describe a no-op
    ctrl.regDst    = 1'b0;
    ctrl.aluSrcImm = 1'b0;
    ctrl.regWrite  = 1'b0;
    ctrl.memRead   = 1'b0;
    ctrl.memWrite  = 1'b0;
    ctrl.branch    = 1'b0;
    ctrl.jump      = 1'b0;
    ctrl.jumpReg   = 1'b0;
    ctrl.shiftOp   = 1'b0;
    ctrl.wbSel     = mipsCorePkg::WbAlu;
    ctrl.aluOp     = mipsCorePkg::AluAdd;

    case (opcode)
      mipsIsaPkg::OpRType: begin
        ctrl.regDst   = 1'b1;
        ctrl.regWrite = 1'b1;
        // ALU control from funct
        case (funct)
          mipsIsaPkg::FnAdd: ctrl.aluOp = mipsCorePkg::AluAdd;
          mipsIsaPkg::FnSub: ctrl.aluOp = mipsCorePkg::AluSub;
          mipsIsaPkg::FnAnd: ctrl.aluOp = mipsCorePkg::AluAnd;
          mipsIsaPkg::FnOr:  ctrl.aluOp = mipsCorePkg::AluOr;
          mipsIsaPkg::FnSlt: ctrl.aluOp = mipsCorePkg::AluSlt;
          mipsIsaPkg::FnSll: begin
            ctrl.aluOp   = mipsCorePkg::AluSll;
            ctrl.shiftOp = 1'b1;
          end
          mipsIsaPkg::FnSrl: begin
            ctrl.aluOp   = mipsCorePkg::AluSrl;
            ctrl.shiftOp = 1'b1;
          end
          mipsIsaPkg::FnJr: begin
            // jr writes nothing
            ctrl.regWrite = 1'b0;
            ctrl.jumpReg  = 1'b1;
          end
          // unknown funct, no write
          default: ctrl.regWrite = 1'b0;
        endcase
      end
      mipsIsaPkg::OpLw: begin
        ctrl.aluSrcImm = 1'b1;
        ctrl.regWrite  = 1'b1;
        ctrl.memRead   = 1'b1;
        ctrl.wbSel     = mipsCorePkg::WbMem;
      end
      mipsIsaPkg::OpSw: begin
        ctrl.aluSrcImm = 1'b1;
        ctrl.memWrite  = 1'b1;
      end
      mipsIsaPkg::OpBeq: begin
        // equality through the zero flag of rs - rt
        ctrl.branch = 1'b1;
        ctrl.aluOp  = mipsCorePkg::AluSub;
      end
      mipsIsaPkg::OpJ: ctrl.jump = 1'b1;
      mipsIsaPkg::OpJal: begin
        ctrl.jump     = 1'b1;
        ctrl.regWrite = 1'b1;
        ctrl.wbSel    = mipsCorePkg::WbLink;
      end
      default: ;
    endcase
  end

endmodule

//--- verilog/mipsIsaPkg.sv
// MIPS-32 instruction set constants: field widths, word types, opcodes, funct codes, link register
package mipsIsaPkg;

  // ==================================================
  // field widths
  // ==================================================
  localparam int ImmWidth    = 16;
  localparam int TargetWidth = 26;
  localparam int ShamtWidth  = 5;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  regAddr_t;
  typedef logic [5:0]  opcode_t;
  typedef logic [5:0]  funct_t;

  // ==================================================
  // opcodes, bits 31..26
  // ==================================================
  localparam opcode_t OpRType = 6'h00;
  localparam opcode_t OpJ     = 6'h02;
  localparam opcode_t OpJal   = 6'h03;
  localparam opcode_t OpBeq   = 6'h04;
  localparam opcode_t OpLw    = 6'h23;
  localparam opcode_t OpSw    = 6'h2B;

  // funct codes for R-type, bits 5..0
  localparam funct_t FnSll = 6'h00;
  localparam funct_t FnSrl = 6'h02;
  localparam funct_t FnJr  = 6'h08;
  localparam funct_t FnAdd = 6'h20;
  localparam funct_t FnSub = 6'h22;
  localparam funct_t FnAnd = 6'h24;
  localparam funct_t FnOr  = 6'h25;
  localparam funct_t FnSlt = 6'h2A;

  // jal destination
  localparam regAddr_t LinkReg = 5'd31;

endpackage

//--- verilog/pcUnit.sv
// program counter register and next-pc selection for branch, jump and jr
`timescale 1ns/10ps

module pcUnit (
  input  logic                                 clk,
  input  logic                                 rst,
  ctrlIf.user                                  ctrl,
  input  logic [mipsIsaPkg::TargetWidth-1:0]   jumpTarget,
  input  mipsIsaPkg::word_t                    branchOffset,
  input  mipsIsaPkg::word_t                    regTarget,
  input  logic                                 aluZero,
  output mipsIsaPkg::word_t                    pc,
  output mipsIsaPkg::word_t                    pcPlus8
);

  mipsIsaPkg::word_t pcReg;
  mipsIsaPkg::word_t pcPlus4;
  mipsIsaPkg::word_t pcNext;

  assign pcPlus4 = pcReg + 32'd4;
  // link value, leaves room for a delay slot
  assign pcPlus8 = pcReg + 32'd8;

  // ==================================================
  // next pc, no delay slot
  // ==================================================
  always_comb begin
    if (ctrl.jumpReg) begin
      pcNext = regTarget;
    end else if (ctrl.jump) begin
      // region of pc + 4, word-aligned target
      pcNext = {pcPlus4[31:28], jumpTarget, 2'b00};
    end else if (ctrl.branch && aluZero) begin
      pcNext = pcPlus4 + {branchOffset[29:0], 2'b00};
    end else begin
      pcNext = pcPlus4;
    end
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      pcReg <= '0;
    end else begin
      pcReg <= pcNext;
    end
  end

  assign pc = pcReg;

endmodule

//--- verilog/regFile.sv
// 32x32 register file with two combinational read ports and one write port
`timescale 1ns/10ps

module regFile (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 writeEn,
  input  mipsIsaPkg::regAddr_t readAddrA,
  input  mipsIsaPkg::regAddr_t readAddrB,
  input  mipsIsaPkg::regAddr_t writeAddr,
  input  mipsIsaPkg::word_t    writeData,
  output mipsIsaPkg::word_t    readDataA,
  output mipsIsaPkg::word_t    readDataB
);

  // register 0 has no storage
  mipsIsaPkg::word_t regs [1:31];

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (writeEn && (writeAddr != 5'd0)) begin
      // writes to r0 dropped
      regs[writeAddr] <= writeData;
    end
  end

  // ==================================================
  // read ports, no bypass from the write port
  // ==================================================
  assign readDataA = (readAddrA == 5'd0) ? '0 : regs[readAddrA];
  assign readDataB = (readAddrB == 5'd0) ? '0 : regs[readAddrB];

endmodule
